// ==== mips_macros.svh ====
// MIPS core constants: opcodes, function codes and datapath widths
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ==============================
// opcodes, instr[31:26]
// ==============================
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ==============================
// R-format function codes, instr[5:0]
// ==============================
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

// ==============================
// widths
// ==============================
`define DATA_W   32
`define REG_AW   5
// data SRAM word address
`define DMEM_AW  7
// jal return address register
`define LINK_REG 5'd31

`endif

// ==== mipsPkg.sv ====
// shared MIPS core types: control word, ALU operation, data SRAM request, writeback
`include "mips_macros.svh"

package mipsPkg;

  // ==============================
  // ALU operations
  // ==============================
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  // ==============================
  // decoded control word
  // ==============================
  typedef struct packed {
    // write to rd instead of rt
    logic  regDst;
    // second ALU operand from immediate
    logic  aluSrc;
    // writeback from data SRAM
    logic  memToReg;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    // beq
    logic  branch;
    // j and jal
    logic  jump;
    // jal only, writes pc+8 to r31
    logic  link;
    aluOpT aluOp;
  } ctrlT;

  // ==============================
  // data SRAM request, strobes active low
  // ==============================
  typedef struct packed {
    logic                cen;
    logic                wen;
    logic                oen;
    logic [`DMEM_AW-1:0] addr;
    logic [`DATA_W-1:0]  wdata;
  } dmemReqT;

  // register writeback, also the observation port
  typedef struct packed {
    logic               valid;
    logic [`REG_AW-1:0] addr;
    logic [`DATA_W-1:0] data;
  } wbInfoT;

endpackage

// ==== pcUnit.sv ====
// program counter with sequential, branch and jump next-address selection
`timescale 1ns/1ps
`include "mips_macros.svh"

module pcUnit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [25:0]          jumpTarget,
  input  logic [`DATA_W-1:0]   branchOffset,
  input  mipsPkg::ctrlT        ctrl,
  input  logic                 aluZero,
  output logic [`DATA_W-1:0]   pc,
  output logic [`DATA_W-1:0]   pcPlus8
);

  logic [`DATA_W-1:0] pcReg;
  logic [`DATA_W-1:0] pcPlus4;
  logic [`DATA_W-1:0] branchAddr;
  logic [`DATA_W-1:0] jumpAddr;
  logic [`DATA_W-1:0] pcNext;
  logic               takeBranch;

  // ==============================
  // candidate addresses
  // ==============================
  assign pcPlus4 = pcReg + `DATA_W'd4;
  // return address for jal
  assign pcPlus8 = pcReg + `DATA_W'd8;
  // word offset relative to the next instruction
  assign branchAddr = pcPlus4 + {branchOffset[`DATA_W-3:0], 2'b00};
  // region bits kept from pc+4
  assign jumpAddr = {pcPlus4[`DATA_W-1:`DATA_W-4], jumpTarget, 2'b00};

  // beq taken only on equal operands
  assign takeBranch = ctrl.branch & aluZero;

  // jump wins over branch, they never overlap in practice
  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (takeBranch) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ==============================
  // pc register
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

// ==== instrDecoder.sv ====
// main and ALU control decode plus immediate sign extension
`timescale 1ns/1ps
`include "mips_macros.svh"

module instrDecoder (
  input  logic [`DATA_W-1:0] instr,
  output mipsPkg::ctrlT      ctrl,
  output logic [`DATA_W-1:0] immExt,
  output logic               legal
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // 16-bit immediate, sign extended
  assign immExt = {{(`DATA_W-16){instr[15]}}, instr[15:0]};

  // ==============================
  // control decode
  // ==============================
  always_comb begin
    // everything off unless the opcode asks for it
    ctrl.regDst   = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memRead  = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.jump     = 1'b0;
    ctrl.link     = 1'b0;
    ctrl.aluOp    = mipsPkg::aluAdd;
    legal         = 1'b1;

    case (opcode)
      `OP_RTYPE: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        // ALU control from funct
        case (funct)
          `FN_ADD: ctrl.aluOp = mipsPkg::aluAdd;
          `FN_SUB: ctrl.aluOp = mipsPkg::aluSub;
          `FN_AND: ctrl.aluOp = mipsPkg::aluAnd;
          `FN_OR:  ctrl.aluOp = mipsPkg::aluOr;
          `FN_SLT: ctrl.aluOp = mipsPkg::aluSlt;
          default: begin
            // unsupported funct, no state change
            ctrl.regWrite = 1'b0;
            legal         = 1'b0;
          end
        endcase
      end
      `OP_LW: begin
        // address = rs + imm
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = mipsPkg::aluAdd;
      end
      `OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = mipsPkg::aluAdd;
      end
      `OP_BEQ: begin
        // compare by subtract, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsPkg::aluSub;
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      `OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode behaves as a nop
        legal = 1'b0;
      end
    endcase
  end

endmodule

// ==== regFile.sv ====
// 32x32 register file, two combinational read ports, one write port, r0 reads zero
`timescale 1ns/1ps
`include "mips_macros.svh"

module regFile (
  input  logic                clk,
  input  logic                rst,
  input  logic [`REG_AW-1:0]  rdAddrA,
  input  logic [`REG_AW-1:0]  rdAddrB,
  input  mipsPkg::wbInfoT     wb,
  output logic [`DATA_W-1:0]  rdDataA,
  output logic [`DATA_W-1:0]  rdDataB
);

  localparam int NumRegs = 1 << `REG_AW;

  logic [`DATA_W-1:0] regs [NumRegs];
  logic               wrEn;

  // r0 is never written
  assign wrEn = wb.valid && (wb.addr != '0);

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ==============================
  // read ports
  // ==============================
  // no bypass, write lands at the closing edge
  always_comb begin
    if (rdAddrA == '0) begin
      rdDataA = '0;
    end else begin
      rdDataA = regs[rdAddrA];
    end
  end

  always_comb begin
    if (rdAddrB == '0) begin
      rdDataB = '0;
    end else begin
      rdDataB = regs[rdAddrB];
    end
  end

endmodule

// ==== execUnit.sv ====
// operand select, ALU, data SRAM request and writeback select
`timescale 1ns/1ps
`include "mips_macros.svh"

module execUnit (
  input  logic                rst,
  input  mipsPkg::ctrlT       ctrl,
  input  logic [`DATA_W-1:0]  rsData,
  input  logic [`DATA_W-1:0]  rtData,
  input  logic [`DATA_W-1:0]  immExt,
  input  logic [`DATA_W-1:0]  pcPlus8,
  input  logic [`REG_AW-1:0]  rtAddr,
  input  logic [`REG_AW-1:0]  rdAddr,
  input  logic [`DATA_W-1:0]  dmemRdata,
  output logic                aluZero,
  output mipsPkg::dmemReqT    dmemReq,
  output mipsPkg::wbInfoT     wbInfo
);

  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] aluResult;
  logic [`REG_AW-1:0] wbAddr;
  logic [`DATA_W-1:0] wbData;

  // ==============================
  // ALU
  // ==============================
  assign opB = ctrl.aluSrc ? immExt : rtData;

  always_comb begin
    case (ctrl.aluOp)
      mipsPkg::aluAdd: aluResult = rsData + opB;
      mipsPkg::aluSub: aluResult = rsData - opB;
      mipsPkg::aluAnd: aluResult = rsData & opB;
      mipsPkg::aluOr:  aluResult = rsData | opB;
      // unsigned compare
      mipsPkg::aluSlt: aluResult = {{(`DATA_W-1){1'b0}}, (rsData < opB)};
      default:         aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == '0);

  // ==============================
  // data SRAM request
  // ==============================
  always_comb begin
    // word address from byte address bits 8:2
    dmemReq.addr  = aluResult[`DMEM_AW+1:2];
    dmemReq.wdata = rtData;
    // strobes idle high during reset
    dmemReq.cen   = !rst || !(ctrl.memRead || ctrl.memWrite);
    dmemReq.wen   = !rst || !ctrl.memWrite;
    dmemReq.oen   = !rst || !ctrl.memRead;
  end

  // ==============================
  // writeback
  // ==============================
  always_comb begin
    if (ctrl.link) begin
      wbAddr = `LINK_REG;
    end else if (ctrl.regDst) begin
      wbAddr = rdAddr;
    end else begin
      wbAddr = rtAddr;
    end
  end

  // pc+8 for jal, load data for lw, else ALU
  assign wbData = ctrl.link     ? pcPlus8 :
                  ctrl.memToReg ? dmemRdata : aluResult;

  assign wbInfo.addr  = wbAddr;
  assign wbInfo.data  = wbData;
  // writes to r0 are dropped here so the port never shows them
  assign wbInfo.valid = rst && ctrl.regWrite && (wbAddr != '0);

endmodule

// ==== mipsCore.sv ====
// single-cycle MIPS core top, instruction and data SRAM ports
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore (
  input  logic                clk,
  input  logic                rst,
  output logic [`DATA_W-1:0]  instrAddr,
  input  logic [`DATA_W-1:0]  instr,
  output mipsPkg::dmemReqT    dmemReq,
  input  logic [`DATA_W-1:0]  dmemRdata,
  output mipsPkg::wbInfoT     wbInfo
);

  mipsPkg::ctrlT      ctrl;
  logic [`DATA_W-1:0] immExt;
  // observed by the bound assertions
  logic               legal;
  logic [`DATA_W-1:0] rsData;
  logic [`DATA_W-1:0] rtData;
  logic [`DATA_W-1:0] pcPlus8;
  logic               aluZero;

  // ==============================
  // fetch
  // ==============================
  pcUnit uPc (
    .clk          (clk),
    .rst          (rst),
    .jumpTarget   (instr[25:0]),
    .branchOffset (immExt),
    .ctrl         (ctrl),
    .aluZero      (aluZero),
    .pc           (instrAddr),
    .pcPlus8      (pcPlus8)
  );

  // ==============================
  // decode and register read
  // ==============================
  instrDecoder uDec (
    .instr  (instr),
    .ctrl   (ctrl),
    .immExt (immExt),
    .legal  (legal)
  );

  // rs and rt read ports, write from writeback
  regFile uRegs (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (instr[25:21]),
    .rdAddrB (instr[20:16]),
    .wb      (wbInfo),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  // ==============================
  // execute, memory, writeback
  // ==============================
  execUnit uExec (
    .rst       (rst),
    .ctrl      (ctrl),
    .rsData    (rsData),
    .rtData    (rtData),
    .immExt    (immExt),
    .pcPlus8   (pcPlus8),
    .rtAddr    (instr[20:16]),
    .rdAddr    (instr[15:11]),
    .dmemRdata (dmemRdata),
    .aluZero   (aluZero),
    .dmemReq   (dmemReq),
    .wbInfo    (wbInfo)
  );

endmodule

// ==== mipsCore_asserts.sv ====
// concurrent protocol checks on the MIPS core ports bound into mipsCore
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore_asserts (
  input logic                clk,
  input logic                rst,
  input logic [`DATA_W-1:0]  instrAddr,
  input mipsPkg::dmemReqT    dmemReq,
  input mipsPkg::wbInfoT     wbInfo,
  input logic                legal
);

  // count of assertion failures
  int unsigned failCount;

  initial failCount = 0;

  // ==============================
  // data SRAM strobes
  // ==============================
  // never read and write in the same access
  strobeExclusive: assert property (@(posedge clk) disable iff (!rst)
    !dmemReq.cen |-> (dmemReq.wen || dmemReq.oen))
    else begin
      $error("wen and oen both low while cen is low");
      failCount++;
    end

  // ==============================
  // fetch and writeback
  // ==============================
  pcAligned: assert property (@(posedge clk) disable iff (!rst)
    instrAddr[1:0] == 2'b00)
    else begin
      $error("instrAddr not word aligned");
      failCount++;
    end

  // r0 writes are filtered before the port
  noZeroWrite: assert property (@(posedge clk) disable iff (!rst)
    (wbInfo.valid && legal) |-> (wbInfo.addr != '0))
    else begin
      $error("writeback targets r0 with valid set");
      failCount++;
    end

  // first cycle out of reset fetches from address 0
  resetFetch: assert property (@(posedge clk)
    $rose(rst) |-> (instrAddr == '0))
    else begin
      $error("instrAddr not 0 in first cycle after reset");
      failCount++;
    end

endmodule

bind mipsCore mipsCore_asserts uAsserts (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .dmemReq   (dmemReq),
  .wbInfo    (wbInfo),
  .legal     (legal)
);

// ==== tbClock.sv ====
// testbench clock and reset source, 20 ns clock, reset low for 4 cycles
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rst
);

  localparam int HalfPeriod  = 10;
  localparam int ResetCycles = 4;
  // release lands just after an edge, like other tb inputs
  localparam int DriveDelay  = 2;

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // active low reset
  initial begin
    rst = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst = 1'b1;
  end

endmodule

// ==== mipsCore_tb.sv ====
// testbench for the single-cycle MIPS core with memory models and trace checking
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCore_tb;

  localparam int ClkPeriod  = 20;
  localparam int DriveDelay = 2;
  localparam int ImemWords  = 256;
  localparam int DmemWords  = 1 << `DMEM_AW;
  localparam int MaxRecs    = 64;
  localparam int MaxTests   = 16;

  // one expected cycle of the trace
  typedef struct packed {
    logic [`DATA_W-1:0]  pc;
    logic                wbValid;
    logic [`REG_AW-1:0]  wbAddr;
    logic [`DATA_W-1:0]  wbData;
    logic                store;
    logic [`DMEM_AW-1:0] stAddr;
    logic [`DATA_W-1:0]  stData;
  } traceRecT;

  logic               clk;
  logic               rst;
  logic [`DATA_W-1:0] instrAddr;
  logic [`DATA_W-1:0] instr;
  mipsPkg::dmemReqT   dmemReq;
  logic [`DATA_W-1:0] dmemRdata;
  mipsPkg::wbInfoT    wbInfo;

  logic [`DATA_W-1:0] imem [ImemWords];
  logic [`DATA_W-1:0] dmem [DmemWords];
  traceRecT           recs [MaxRecs];
  int                 recTest [MaxRecs];
  logic [8*16-1:0]    testNames [MaxTests];
  mipsPkg::dmemReqT   reqAtEdge;
  int                 nRec;
  int                 nTests;
  int                 recIdx;
  int                 curTest;
  int                 testErrors;
  int                 totalErrors;
  int                 testsOk;
  int                 testsBad;
  logic               loaded;
  logic               loadOk;

  tbClock uClk (
    .clk (clk),
    .rst (rst)
  );

  mipsCore uut (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .wbInfo    (wbInfo)
  );

  // ==============================
  // memory models
  // ==============================
  // combinational read gated by cen and oen
  assign dmemRdata = (!dmemReq.cen && !dmemReq.oen) ? dmem[dmemReq.addr] : '0;

  // store captured at the edge and committed with the input update
  always @(posedge clk) begin
    reqAtEdge = dmemReq;
    #DriveDelay;
    if (!reqAtEdge.cen && !reqAtEdge.wen) begin
      dmem[reqAtEdge.addr] = reqAtEdge.wdata;
    end
    instr = imem[instrAddr[9:2]];
  end

  // ==============================
  // stimulus file
  // ==============================
  task automatic loadInput(output logic ok);
    int              fd;
    int              cnt;
    int              fileTest;
    logic [8*64-1:0] tok;
    logic [8*160-1:0] rest;
    logic [31:0]     idx;
    logic [31:0]     word;
    logic [31:0]     ePc;
    logic [31:0]     eVal;
    logic [31:0]     eAddr;
    logic [31:0]     eData;
    logic [31:0]     eSt;
    logic [31:0]     eStAddr;
    logic [31:0]     eStData;
    ok = 1'b1;
    fileTest = -1;
    // unused words decode as an unknown opcode tagged with their index
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = 32'hFC00_0000 | i;
    end
    // every word carries its own address
    for (int i = 0; i < DmemWords; i++) begin
      dmem[i] = 32'hDA7A_0000 | i;
    end
    fd = $fopen("program_input.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          cnt = $fgets(rest, fd);
        end else if (tok == "P") begin
          cnt = $fscanf(fd, "%h %h", idx, word);
          if (cnt != 2) begin
            ok = 1'b0;
          end
          imem[idx[7:0]] = word;
        end else if (tok == "D") begin
          cnt = $fscanf(fd, "%h %h", idx, word);
          if (cnt != 2) begin
            ok = 1'b0;
          end
          dmem[idx[`DMEM_AW-1:0]] = word;
        end else if (tok == "T" && fileTest < MaxTests - 1) begin
          cnt = $fscanf(fd, "%s", tok);
          if (cnt != 1) begin
            ok = 1'b0;
          end
          fileTest++;
          testNames[fileTest] = tok[8*16-1:0];
        end else if (tok == "E" && nRec < MaxRecs && fileTest >= 0) begin
          cnt = $fscanf(fd, "%h %h %h %h %h %h %h",
                        ePc, eVal, eAddr, eData, eSt, eStAddr, eStData);
          if (cnt != 7) begin
            ok = 1'b0;
          end
          recs[nRec] = {ePc, eVal[0], eAddr[`REG_AW-1:0], eData,
                        eSt[0], eStAddr[`DMEM_AW-1:0], eStData};
          recTest[nRec] = fileTest;
          nRec++;
        end else begin
          ok = 1'b0;
        end
      end
      $fclose(fd);
    end
    nTests = fileTest + 1;
    if (nRec == 0) begin
      ok = 1'b0;
    end
  endtask

  // ==============================
  // checking and reporting
  // ==============================
  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0s: %0s expected %h, actual %h",
               testNames[curTest], what, expected, actual);
      testErrors++;
      totalErrors++;
    end
  endtask

  task automatic reportTest(input int testIdx);
    if (testErrors == 0) begin
      testsOk++;
      $display("%0s: PASS", testNames[testIdx]);
    end else begin
      testsBad++;
      $display("%0s: FAIL, %0d mismatches", testNames[testIdx], testErrors);
    end
    testErrors = 0;
  endtask

  task automatic checkCycle(input traceRecT rec, input int testIdx);
    logic stored;
    // new test marker closes the previous test
    if (testIdx != curTest) begin
      reportTest(curTest);
      curTest = testIdx;
    end
    stored = !dmemReq.cen && !dmemReq.wen;
    checkValue("instrAddr", rec.pc, instrAddr);
    checkValue("wb valid", rec.wbValid, wbInfo.valid);
    if (rec.wbValid) begin
      checkValue("wb addr", rec.wbAddr, wbInfo.addr);
      checkValue("wb data", rec.wbData, wbInfo.data);
    end
    checkValue("store", rec.store, stored);
    if (rec.store) begin
      checkValue("store addr", rec.stAddr, dmemReq.addr);
      checkValue("store data", rec.stData, dmemReq.wdata);
    end
    // all strobes idle while reset is held
    if (!rst) begin
      checkValue("strobes", 3'b111, {dmemReq.cen, dmemReq.wen, dmemReq.oen});
    end
  endtask

  // outputs sampled before the edge updates any state
  always @(posedge clk) begin
    if (loaded && recIdx < nRec) begin
      checkCycle(recs[recIdx], recTest[recIdx]);
      recIdx = recIdx + 1;
    end
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin
    instr = '0;
    loaded = 1'b0;
    nRec = 0;
    nTests = 0;
    recIdx = 0;
    testErrors = 0;
    totalErrors = 0;
    testsOk = 0;
    testsBad = 0;
    loadInput(loadOk);
    if (!loadOk) begin
      $display("stimulus file program_input.txt is missing or malformed");
      $display("Test failed");
      $finish;
    end else begin
      // reset pc is 0
      instr = imem[0];
      curTest = recTest[0];
      loaded = 1'b1;
      wait (recIdx == nRec);
      reportTest(curTest);
      $display("summary: %0d tests, %0d ok, %0d with errors, %0d assertion failures",
               nTests, testsOk, testsBad, uut.uAsserts.failCount);
      if (totalErrors == 0 && uut.uAsserts.failCount == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // trace length plus margin
  initial begin
    wait (loaded);
    #((nRec + 10) * ClkPeriod);
    $display("watchdog expired, the trace did not complete in time");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
mipsPkg.sv
pcUnit.sv
instrDecoder.sv
regFile.sv
execUnit.sv
mipsCore.sv
mipsCore_asserts.sv
tbClock.sv
mipsCore_tb.sv

// ==== program_input.txt ====
# P word-index instr | D word-index data | T test-name
# E pc wbValid wbAddr wbData store storeAddr storeData (all hex)
P 00 8C010000
P 01 8C020004
P 02 8C030008
P 03 8C04000C
P 04 00222820
P 05 00223022
P 06 00243824
P 07 00244025
P 08 0041482A
P 09 0061502A
P 0A 00220020
P 0B 00015820
P 0C AC050010
P 0D AC880014
P 0E 8C0C0010
P 0F 8C0D0020
P 10 102B0002
P 11 00217020
P 12 00217020
P 13 10220005
P 14 08000018
P 18 0C000020
P 20 03E07820
P 21 08000021
D 00 00000007
D 01 00000005
D 02 FFFFFFFE
D 03 0000000C
T reset
E 00000000 0 00 00000000 0 00 00000000
E 00000000 0 00 00000000 0 00 00000000
E 00000000 0 00 00000000 0 00 00000000
E 00000000 0 00 00000000 0 00 00000000
T load
E 00000000 1 01 00000007 0 00 00000000
E 00000004 1 02 00000005 0 00 00000000
E 00000008 1 03 FFFFFFFE 0 00 00000000
E 0000000C 1 04 0000000C 0 00 00000000
T rtype
E 00000010 1 05 0000000C 0 00 00000000
E 00000014 1 06 00000002 0 00 00000000
E 00000018 1 07 00000004 0 00 00000000
E 0000001C 1 08 0000000F 0 00 00000000
E 00000020 1 09 00000001 0 00 00000000
E 00000024 1 0A 00000000 0 00 00000000
E 00000028 0 00 00000000 0 00 00000000
E 0000002C 1 0B 00000007 0 00 00000000
T loadStore
E 00000030 0 00 00000000 1 04 0000000C
E 00000034 0 00 00000000 1 08 0000000F
E 00000038 1 0C 0000000C 0 00 00000000
E 0000003C 1 0D 0000000F 0 00 00000000
T branch
E 00000040 0 00 00000000 0 00 00000000
E 0000004C 0 00 00000000 0 00 00000000
T jump
E 00000050 0 00 00000000 0 00 00000000
E 00000060 1 1F 00000068 0 00 00000000
E 00000080 1 0F 00000068 0 00 00000000
E 00000084 0 00 00000000 0 00 00000000
